// ==== sim.f ====
common/leaf_cfg_pkg.sv
common/port_ctrl_if.sv
verilog/cfg_receiver.sv
config_controls/config_controls.sv
config_controls/credit_tracker.sv
verilog/leaf_config_top.sv
verification/leaf_config_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the leaf configuration testbench with Verilator and runs it.
# The script's exit status is the simulator's own exit status.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot change to the project root"
    exit 1
fi

verilator --binary --timing -Wno-fatal -f sim.f \
    --top-module leaf_config_tb -Mdir obj_dir -o leaf_config_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/leaf_config_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0

// ==== verification/leaf_config_tb.sv ====
`timescale 1ns/1ps

module leaf_config_tb import leaf_cfg_pkg::*; ();

    localparam int MAX_CYCLES = 5000;

    logic                               clk;
    logic                               reset;
    logic                               cfg_req;
    cfg_packet_t                        cfg_packet;
    logic                               cfg_ack;
    out_mask_t                          send;
    logic [NUM_IN_PORTS*LEAF_BITS-1:0]  src_leaf;
    logic [NUM_IN_PORTS*PORT_BITS-1:0]  src_port;
    logic [NUM_OUT_PORTS*LEAF_BITS-1:0] dst_leaf;
    logic [NUM_OUT_PORTS*PORT_BITS-1:0] dst_port;
    logic [NUM_OUT_PORTS*ADDR_BITS-1:0] freespace;
    logic [NUM_OUT_PORTS*ADDR_BITS-1:0] bram_addr;

    integer      seed = 32'h10ef_ae82;
    int          cycle_count = 0;
    // Cycle at which the pending packet reaches the tracker
    int          evt_cycle = -1;
    cfg_packet_t evt_pkt;

    // Expected state
    leaf_id_t   exp_src_leaf [NUM_IN_PORTS];
    port_id_t   exp_src_port [NUM_IN_PORTS];
    leaf_id_t   exp_dst_leaf [NUM_OUT_PORTS];
    port_id_t   exp_dst_port [NUM_OUT_PORTS];
    freespace_t exp_free     [NUM_OUT_PORTS];
    bram_addr_t exp_addr     [NUM_OUT_PORTS];

    leaf_config_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .cfg_req_i    (cfg_req),
        .cfg_packet_i (cfg_packet),
        .cfg_ack_o    (cfg_ack),
        .send_i       (send),
        .src_leaf_o   (src_leaf),
        .src_port_o   (src_port),
        .dst_leaf_o   (dst_leaf),
        .dst_port_o   (dst_port),
        .freespace_o  (freespace),
        .bram_addr_o  (bram_addr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    task automatic apply_packet(input cfg_packet_t pkt, output out_mask_t load_mask,
                                output out_mask_t add_mask, output freespace_t ld_free,
                                output bram_addr_t ld_addr);
        int field;
        int self_port;
        load_mask = '0;
        add_mask  = '0;
        ld_free   = pkt[FREESPACE_LSB +: ADDR_BITS];
        ld_addr   = pkt[BRAM_ADDR_LSB +: ADDR_BITS];
        field     = int'(pkt[PORT_LSB +: PORT_BITS]);
        self_port = int'(pkt[SELF_PORT_LSB +: PORT_BITS]);
        if (pkt[VALID_POS]) begin
            if (field == 1 && self_port >= 2 && self_port <= 8) begin
                exp_src_leaf[self_port - 2] = pkt[ROUTE_LEAF_LSB +: LEAF_BITS];
                exp_src_port[self_port - 2] = pkt[ROUTE_PORT_LSB +: PORT_BITS];
            end else if (field == 0 && self_port >= 9) begin
                exp_dst_leaf[self_port - 9] = pkt[ROUTE_LEAF_LSB +: LEAF_BITS];
                exp_dst_port[self_port - 9] = pkt[ROUTE_PORT_LSB +: PORT_BITS];
                load_mask[self_port - 9]    = 1'b1;
            end else if (field >= 9) begin
                add_mask[field - 9] = pkt[0];
            end
        end
    endtask

    // One update per clock, plus the run limit
    always @(posedge clk) begin
        out_mask_t  load_mask;
        out_mask_t  add_mask;
        freespace_t ld_free;
        bram_addr_t ld_addr;
        cycle_count = cycle_count + 1;
        assert (cycle_count < MAX_CYCLES)
            else stop_with_error("Timeout: the tests did not finish within the cycle limit");
        load_mask = '0;
        add_mask  = '0;
        ld_free   = '0;
        ld_addr   = '0;
        if (reset) begin
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                exp_src_leaf[i] = '0;
                exp_src_port[i] = 4'd9;
            end
            for (int j = 0; j < NUM_OUT_PORTS; j++) begin
                exp_dst_leaf[j] = '0;
                exp_dst_port[j] = 4'd2;
                exp_free[j]     = 7'd127;
                exp_addr[j]     = '0;
            end
        end else begin
            if (cycle_count == evt_cycle) begin
                apply_packet(evt_pkt, load_mask, add_mask, ld_free, ld_addr);
            end
            for (int j = 0; j < NUM_OUT_PORTS; j++) begin
                if (load_mask[j]) begin
                    exp_free[j] = ld_free;
                    exp_addr[j] = ld_addr;
                end else begin
                    if (add_mask[j] && !send[j] && exp_free[j] != 7'd127) begin
                        exp_free[j] = exp_free[j] + 7'd1;
                    end else if (send[j] && !add_mask[j] && exp_free[j] != 7'd0) begin
                        exp_free[j] = exp_free[j] - 7'd1;
                    end
                    // 7-bit pointer wraps at 128 by itself
                    if (send[j]) begin
                        exp_addr[j] = exp_addr[j] + 7'd1;
                    end
                end
            end
        end
    end

    ////////////////////
    // Helpers
    ////////////////////
    function automatic cfg_packet_t make_packet(input logic valid, input port_id_t field,
                                                input port_id_t self_port, input leaf_id_t leaf,
                                                input port_id_t port, input bram_addr_t addr,
                                                input freespace_t free, input logic credit);
        cfg_packet_t pkt;
        pkt = '0;
        pkt[VALID_POS] = valid;
        // Leaf field is carried but not used by the leaf
        pkt[LEAF_LSB +: LEAF_BITS]           = leaf_id_t'($random(seed));
        pkt[PORT_LSB +: PORT_BITS]           = field;
        pkt[SELF_PORT_LSB +: PORT_BITS]      = self_port;
        pkt[ROUTE_LEAF_LSB +: LEAF_BITS]     = leaf;
        pkt[ROUTE_PORT_LSB +: PORT_BITS]     = port;
        pkt[BRAM_ADDR_LSB +: ADDR_BITS]      = addr;
        pkt[FREESPACE_LSB +: ADDR_BITS]      = free;
        pkt[0]                               = credit;
        return pkt;
    endfunction

    function automatic cfg_packet_t random_route(input logic valid, input port_id_t field,
                                                 input int self_port);
        return make_packet(valid, field, port_id_t'(self_port), leaf_id_t'($random(seed)),
                           port_id_t'($random(seed)), bram_addr_t'($random(seed)),
                           freespace_t'($random(seed)), 1'b0);
    endfunction

    function automatic cfg_packet_t credit_packet(input int idx, input logic credit);
        return make_packet(1'b1, port_id_t'(OUT_PORT_BASE + idx), '0, '0, '0, '0, '0, credit);
    endfunction

    task automatic check_value(input string name, input int port, input int got,
                               input int expected);
        assert (got == expected)
            else stop_with_error($sformatf("mismatch at %0t: %s of port %0d is %0d, expected %0d",
                                           $time, name, port, got, expected));
    endtask

    task automatic check_outputs();
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            check_value("src_leaf", i + 2, int'(src_leaf[i*LEAF_BITS +: LEAF_BITS]),
                        int'(exp_src_leaf[i]));
            check_value("src_port", i + 2, int'(src_port[i*PORT_BITS +: PORT_BITS]),
                        int'(exp_src_port[i]));
        end
        for (int j = 0; j < NUM_OUT_PORTS; j++) begin
            check_value("dst_leaf", j + 9, int'(dst_leaf[j*LEAF_BITS +: LEAF_BITS]),
                        int'(exp_dst_leaf[j]));
            check_value("dst_port", j + 9, int'(dst_port[j*PORT_BITS +: PORT_BITS]),
                        int'(exp_dst_port[j]));
            check_value("freespace", j + 9, int'(freespace[j*ADDR_BITS +: ADDR_BITS]),
                        int'(exp_free[j]));
            check_value("bram_addr", j + 9, int'(bram_addr[j*ADDR_BITS +: ADDR_BITS]),
                        int'(exp_addr[j]));
        end
    endtask

    // Full four-phase exchange, req held for extra cycles after ack
    task automatic send_cfg(input cfg_packet_t pkt, input int hold);
        int waited;
        cfg_packet = pkt;
        cfg_req    = 1'b1;
        evt_pkt    = pkt;
        evt_cycle  = cycle_count + 4;
        waited     = 0;
        while (cfg_ack !== 1'b1) begin
            @(posedge clk);
            #1;
            waited++;
            assert (waited <= 8) else stop_with_error("ack did not rise after req went high");
        end
        assert (waited == 2)
            else stop_with_error($sformatf("mismatch at %0t: ack rose after %0d cycles, expected 2",
                                           $time, waited));
        repeat (hold) begin
            @(posedge clk);
            #1;
            assert (cfg_ack === 1'b1) else stop_with_error("ack fell while req was still high");
        end
        cfg_req = 1'b0;
        waited  = 0;
        while (cfg_ack !== 1'b0) begin
            @(posedge clk);
            #1;
            waited++;
            assert (waited <= 8) else stop_with_error("ack did not fall after req went low");
        end
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        check_outputs();
    endtask

    task automatic run_sends(input out_mask_t mask, input int cycles);
        send = mask;
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
        send = '0;
        check_outputs();
    endtask

    ////////////////////
    // Directed tests
    ////////////////////
    task automatic check_reset_values();
        assert (cfg_ack === 1'b0) else stop_with_error("ack is not low after reset");
        check_outputs();
    endtask

    task automatic run_handshake();
        send_cfg(random_route(1'b1, PORT_CFG_IN, 4), 6);
        // Acknowledged but ignored
        send_cfg(random_route(1'b0, PORT_CFG_OUT, 11), 2);
        send_cfg(random_route(1'b0, PORT_CFG_IN, 6), 0);
    endtask

    task automatic configure_inputs();
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            send_cfg(random_route(1'b1, PORT_CFG_IN, IN_PORT_BASE + i), i % 3);
        end
        send_cfg(random_route(1'b1, PORT_CFG_OUT, 13), 0);
    endtask

    task automatic configure_outputs();
        for (int j = 0; j < NUM_OUT_PORTS; j++) begin
            send_cfg(random_route(1'b1, PORT_CFG_OUT, OUT_PORT_BASE + j), 1);
        end
    endtask

    task automatic credit_and_send();
        send_cfg(make_packet(1'b1, PORT_CFG_OUT, 4'd12, 6'd5, 4'd3, 7'd120, 7'd120, 1'b0), 0);
        // Credit past the top of the count
        repeat (9) send_cfg(credit_packet(3, 1'b1), 0);
        // Credit and send in the same cycle cancel out
        send = out_mask_t'(1 << 3);
        send_cfg(credit_packet(3, 1'b1), 0);
        // Flag clear returns no credit
        send_cfg(credit_packet(3, 1'b0), 0);
        // Drain past zero, pointer wraps
        run_sends(out_mask_t'(1 << 3), 130);
        send_cfg(credit_packet(3, 1'b1), 0);
        send_cfg(credit_packet(0, 1'b1), 1);
        run_sends(out_mask_t'(7'h55), 5);
        send_cfg(credit_packet(3, 1'b0), 0);
        send_cfg(credit_packet(6, 1'b1), 0);
        run_sends(out_mask_t'(7'h7f), 3);
    endtask

    task automatic load_priority();
        send = out_mask_t'(7'h22);
        send_cfg(make_packet(1'b1, PORT_CFG_OUT, 4'd14, 6'd9, 4'd7, 7'd126, 7'd3, 1'b0), 0);
        repeat (6) begin
            @(posedge clk);
            #1;
        end
        send = '0;
        @(posedge clk);
        #1;
        check_outputs();
    endtask

    initial begin
        reset      = 1'b1;
        cfg_req    = 1'b0;
        cfg_packet = '0;
        send       = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        check_reset_values();
        run_handshake();
        configure_inputs();
        configure_outputs();
        credit_and_send();
        load_priority();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== verilog/leaf_config_top.sv ====
`timescale 1ns/1ps

module leaf_config_top import leaf_cfg_pkg::*; (
    input  logic                                clk,
    input  logic                                reset,

    // Configuration link
    input  logic                                cfg_req_i,
    input  logic [PACKET_BITS-1:0]              cfg_packet_i,
    output logic                                cfg_ack_o,

    // One bit per output port, a word leaves each cycle it is high
    input  logic [NUM_OUT_PORTS-1:0]            send_i,

    // Input port source routes, entry 0 is port 2
    output logic [NUM_IN_PORTS*LEAF_BITS-1:0]   src_leaf_o,
    output logic [NUM_IN_PORTS*PORT_BITS-1:0]   src_port_o,

    // Output port state, entry 0 is port 9
    output logic [NUM_OUT_PORTS*LEAF_BITS-1:0]  dst_leaf_o,
    output logic [NUM_OUT_PORTS*PORT_BITS-1:0]  dst_port_o,
    output logic [NUM_OUT_PORTS*ADDR_BITS-1:0]  freespace_o,
    output logic [NUM_OUT_PORTS*ADDR_BITS-1:0]  bram_addr_o
);

    logic        pkt_valid;
    cfg_packet_t pkt;

    port_ctrl_if ctrl ();

    cfg_receiver i_cfg_receiver (
        .clk          (clk),
        .reset        (reset),
        .cfg_req_i    (cfg_req_i),
        .cfg_packet_i (cfg_packet_i),
        .cfg_ack_o    (cfg_ack_o),
        .pkt_valid_o  (pkt_valid),
        .pkt_o        (pkt)
    );

    config_controls i_config_controls (
        .clk          (clk),
        .reset        (reset),
        .pkt_valid_i  (pkt_valid),
        .pkt_i        (pkt),
        .ctrl         (ctrl.bank),
        .src_leaf_o   (src_leaf_o),
        .src_port_o   (src_port_o),
        .dst_leaf_o   (dst_leaf_o),
        .dst_port_o   (dst_port_o)
    );

    credit_tracker i_credit_tracker (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl.tracker),
        .send_i       (send_i),
        .freespace_o  (freespace_o),
        .bram_addr_o  (bram_addr_o)
    );

endmodule

// ==== config_controls/credit_tracker.sv ====
`timescale 1ns/1ps

module credit_tracker import leaf_cfg_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    port_ctrl_if.tracker                   ctrl,
    input  out_mask_t                      send_i,
    output freespace_t [NUM_OUT_PORTS-1:0] freespace_o,
    output bram_addr_t [NUM_OUT_PORTS-1:0] bram_addr_o
);

    freespace_t [NUM_OUT_PORTS-1:0] free_next;
    bram_addr_t [NUM_OUT_PORTS-1:0] addr_next;

    ////////////////////
    // Next count and pointer
    ////////////////////
    always_comb begin
        for (int i = 0; i < NUM_OUT_PORTS; i++) begin
            free_next[i] = freespace_o[i];
            addr_next[i] = bram_addr_o[i];

            if (ctrl.load_en[i]) begin
                // Load wins over credit and send
                free_next[i] = ctrl.load_free[i];
                addr_next[i] = ctrl.load_addr[i];
            end else begin
                case ({ctrl.add_en[i], send_i[i]})
                    2'b10: begin
                        if (freespace_o[i] != FREESPACE_MAX) begin
                            free_next[i] = freespace_o[i] + 1'b1;
                        end
                    end
                    2'b01: begin
                        if (freespace_o[i] != '0) begin
                            free_next[i] = freespace_o[i] - 1'b1;
                        end
                    end
                    // Credit and send in the same cycle cancel out
                    default: begin
                        free_next[i] = freespace_o[i];
                    end
                endcase

                // Pointer wraps at the top of the BRAM
                if (send_i[i]) begin
                    addr_next[i] = bram_addr_o[i] + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Counter registers
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                freespace_o[i] <= FREESPACE_RST;
                bram_addr_o[i] <= ADDR_RST;
            end
        end else begin
            freespace_o <= free_next;
            bram_addr_o <= addr_next;
        end
    end

endmodule

// ==== config_controls/config_controls.sv ====
`timescale 1ns/1ps

module config_controls import leaf_cfg_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           pkt_valid_i,
    input  cfg_packet_t                    pkt_i,
    port_ctrl_if.bank                      ctrl,
    output leaf_id_t [NUM_IN_PORTS-1:0]    src_leaf_o,
    output port_id_t [NUM_IN_PORTS-1:0]    src_port_o,
    output leaf_id_t [NUM_OUT_PORTS-1:0]   dst_leaf_o,
    output port_id_t [NUM_OUT_PORTS-1:0]   dst_port_o
);

    logic                    pkt_valid_q;
    cfg_packet_t             pkt_q;

    port_id_t                port_field;
    payload_t                payload;
    port_id_t                self_port;
    leaf_id_t                route_leaf;
    port_id_t                route_port;
    bram_addr_t              bram_addr;
    freespace_t              freespace;

    logic [NUM_IN_PORTS-1:0] in_hit;
    out_mask_t               out_hit;
    out_mask_t               credit_hit;

    ////////////////////
    // Input stage
    ////////////////////
    // Packets with the valid bit clear are dropped here
    always_ff @(posedge clk) begin
        if (reset) begin
            pkt_valid_q <= 1'b0;
        end else begin
            pkt_valid_q <= pkt_valid_i && pkt_i[VALID_POS];
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_valid_i) begin
            pkt_q <= pkt_i;
        end
    end

    // Field split, leaf field not needed here
    assign port_field = pkt_q[PORT_LSB +: PORT_BITS];
    assign payload    = pkt_q[PAYLOAD_BITS-1:0];
    assign self_port  = payload[SELF_PORT_LSB +: PORT_BITS];
    assign route_leaf = payload[ROUTE_LEAF_LSB +: LEAF_BITS];
    assign route_port = payload[ROUTE_PORT_LSB +: PORT_BITS];
    assign bram_addr  = payload[BRAM_ADDR_LSB +: ADDR_BITS];
    assign freespace  = payload[FREESPACE_LSB +: ADDR_BITS];

    ////////////////////
    // Port decode
    ////////////////////
    always_comb begin
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            in_hit[i] = pkt_valid_q && (port_field == PORT_CFG_IN) &&
                        (self_port == port_id_t'(IN_PORT_BASE + i));
        end
        for (int j = 0; j < NUM_OUT_PORTS; j++) begin
            out_hit[j]    = pkt_valid_q && (port_field == PORT_CFG_OUT) &&
                            (self_port == port_id_t'(OUT_PORT_BASE + j));
            // Credit packets address the output port directly
            credit_hit[j] = pkt_valid_q && (port_field == port_id_t'(OUT_PORT_BASE + j));
        end
    end

    ////////////////////
    // Route registers
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                src_leaf_o[i] <= LEAF_RST;
                src_port_o[i] <= SRC_PORT_RST;
            end
            for (int j = 0; j < NUM_OUT_PORTS; j++) begin
                dst_leaf_o[j] <= LEAF_RST;
                dst_port_o[j] <= DST_PORT_RST;
            end
        end else begin
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                if (in_hit[i]) begin
                    src_leaf_o[i] <= route_leaf;
                    src_port_o[i] <= route_port;
                end
            end
            for (int j = 0; j < NUM_OUT_PORTS; j++) begin
                if (out_hit[j]) begin
                    dst_leaf_o[j] <= route_leaf;
                    dst_port_o[j] <= route_port;
                end
            end
        end
    end

    ////////////////////
    // Tracker controls
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.load_en <= '0;
            ctrl.add_en  <= '0;
        end else begin
            ctrl.load_en <= out_hit;
            ctrl.add_en  <= credit_hit & {NUM_OUT_PORTS{payload[CREDIT_BIT]}};
        end
    end

    // Load values line up with the load_en pulse
    always_ff @(posedge clk) begin
        for (int j = 0; j < NUM_OUT_PORTS; j++) begin
            if (out_hit[j]) begin
                ctrl.load_addr[j] <= bram_addr;
                ctrl.load_free[j] <= freespace;
            end
        end
    end

endmodule

// ==== verilog/cfg_receiver.sv ====
`timescale 1ns/1ps

module cfg_receiver import leaf_cfg_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        cfg_req_i,
    input  cfg_packet_t cfg_packet_i,
    output logic        cfg_ack_o,
    output logic        pkt_valid_o,
    output cfg_packet_t pkt_o
);

    rx_state_t   state;
    rx_state_t   state_next;
    cfg_packet_t pkt_q;
    logic        capture;

    // Sender holds the packet stable while req is high
    assign capture = (state == RX_IDLE) && cfg_req_i;

    ////////////////////
    // Handshake FSM
    ////////////////////
    always_comb begin
        state_next = state;
        case (state)
            RX_IDLE: begin
                if (cfg_req_i) begin
                    state_next = RX_ACK;
                end
            end
            RX_ACK: begin
                state_next = RX_WAIT_LOW;
            end
            RX_WAIT_LOW: begin
                // Slow sender parks us here
                if (!cfg_req_i) begin
                    state_next = RX_IDLE;
                end
            end
            default: begin
                state_next = RX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RX_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Packet register
    always_ff @(posedge clk) begin
        if (capture) begin
            pkt_q <= cfg_packet_i;
        end
    end

    ////////////////////
    // Outputs
    ////////////////////
    // Valid for the one cycle spent in RX_ACK
    assign pkt_valid_o = (state == RX_ACK);
    // Ack held until req goes low
    assign cfg_ack_o   = (state == RX_WAIT_LOW);
    assign pkt_o       = pkt_q;

endmodule

// ==== common/port_ctrl_if.sv ====
`timescale 1ns/1ps

interface port_ctrl_if import leaf_cfg_pkg::*; ();

    // Per output port pulses, one cycle wide
    out_mask_t load_en;
    out_mask_t add_en;

    // Start address and credit taken on load_en
    bram_addr_t [NUM_OUT_PORTS-1:0] load_addr;
    freespace_t [NUM_OUT_PORTS-1:0] load_free;

    modport bank (
        output load_en,
        output add_en,
        output load_addr,
        output load_free
    );

    modport tracker (
        input load_en,
        input add_en,
        input load_addr,
        input load_free
    );

endinterface

// ==== common/leaf_cfg_pkg.sv ====
package leaf_cfg_pkg;

    ////////////////////
    // Widths and port counts
    ////////////////////
    localparam int PACKET_BITS   = 97;
    localparam int LEAF_BITS     = 6;
    localparam int PORT_BITS     = 4;
    localparam int ADDR_BITS     = 7;
    localparam int PAYLOAD_BITS  = 64;

    localparam int NUM_IN_PORTS  = 7;
    localparam int NUM_OUT_PORTS = 7;

    // Port numbering inside the leaf
    localparam int IN_PORT_BASE  = 2;
    localparam int OUT_PORT_BASE = 9;

    ////////////////////
    // Header field positions
    ////////////////////
    localparam int VALID_POS = PACKET_BITS - 1;
    localparam int LEAF_LSB  = VALID_POS - LEAF_BITS;
    localparam int PORT_LSB  = LEAF_LSB - PORT_BITS;

    // Payload fields, from the top of the payload down
    localparam int SELF_PORT_LSB  = PAYLOAD_BITS - PORT_BITS;
    localparam int ROUTE_LEAF_LSB = SELF_PORT_LSB - LEAF_BITS;
    localparam int ROUTE_PORT_LSB = ROUTE_LEAF_LSB - PORT_BITS;
    localparam int BRAM_ADDR_LSB  = ROUTE_PORT_LSB - ADDR_BITS;
    localparam int FREESPACE_LSB  = BRAM_ADDR_LSB - ADDR_BITS;
    // Credit return flag
    localparam int CREDIT_BIT     = 0;

    ////////////////////
    // Types
    ////////////////////
    typedef logic [PACKET_BITS-1:0]   cfg_packet_t;
    typedef logic [LEAF_BITS-1:0]     leaf_id_t;
    typedef logic [PORT_BITS-1:0]     port_id_t;
    typedef logic [ADDR_BITS-1:0]     bram_addr_t;
    typedef logic [ADDR_BITS-1:0]     freespace_t;
    typedef logic [PAYLOAD_BITS-1:0]  payload_t;
    typedef logic [NUM_OUT_PORTS-1:0] out_mask_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_ACK,
        RX_WAIT_LOW
    } rx_state_t;

    // Port field codes
    localparam port_id_t PORT_CFG_OUT = 4'd0;
    localparam port_id_t PORT_CFG_IN  = 4'd1;

    ////////////////////
    // Reset values
    ////////////////////
    localparam port_id_t   SRC_PORT_RST  = 4'd9;
    localparam port_id_t   DST_PORT_RST  = 4'd2;
    localparam leaf_id_t   LEAF_RST      = '0;
    localparam bram_addr_t ADDR_RST      = '0;
    // Buffer starts empty, so full credit
    localparam freespace_t FREESPACE_MAX = 7'd127;
    localparam freespace_t FREESPACE_RST = FREESPACE_MAX;

endpackage
